// ==== logic/vga_output.sv ====
module vga_output (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable,
  input  vga_pkg::vga_pixel_t pix,
  input  logic                visible,
  output logic [3:0]          red,
  output logic [3:0]          green,
  output logic [3:0]          blue,
  output logic                hsync,
  output logic                vsync
);
  import vga_pkg::*;

  vga_rgb_t   blanked;
  vga_pixel_t out_q;

  // The monitor expects black during the porches and sync pulses.
  assign blanked = visible ? pix.rgb : '0;

  // --------------------------------------------------------------------------
  // Pin register.
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q.rgb   <= '0;
      out_q.hsync <= ~SYNC_ACTIVE;
      out_q.vsync <= ~SYNC_ACTIVE;
    end else if (enable) begin
      out_q.rgb   <= blanked;
      out_q.hsync <= pix.hsync;  // syncs are not blanked.
      out_q.vsync <= pix.vsync;
    end
  end

  assign red   = out_q.rgb.red;
  assign green = out_q.rgb.green;
  assign blue  = out_q.rgb.blue;
  assign hsync = out_q.hsync;
  assign vsync = out_q.vsync;

endmodule

// ==== logic/vga_pattern.sv ====
module vga_pattern (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable,
  input  vga_pkg::pattern_e   pattern_sel,
  input  vga_pkg::vga_pos_t   pos,
  output vga_pkg::vga_pixel_t pix,
  output logic                visible
);
  import vga_pkg::*;

  logic [COLUMN_BITS-1:0] bar_quotient;
  logic [2:0]             bar_index;
  logic                   checker_on;
  logic [3:0]             ramp;
  vga_rgb_t               color;
  vga_pixel_t             pix_q;
  logic                   visible_q;

  // --------------------------------------------------------------------------
  // Pattern terms.
  // --------------------------------------------------------------------------

  assign bar_quotient = pos.column / COLUMN_BITS'(BAR_WIDTH);
  assign bar_index    = (bar_quotient > 7) ? 3'd7 : bar_quotient[2:0];  // past the bars is black.

  assign checker_on = pos.column[CHECKER_SHIFT] ^ pos.row[CHECKER_SHIFT];

  assign ramp = pos.column[9:6];  // ten steps over the visible width.

  always_comb begin
    color = '0;
    unique case (pattern_sel)
      PAT_BARS: begin
        color = BAR_COLORS[bar_index];
      end
      PAT_CHECKER: begin
        if (checker_on) begin
          color = '{red: 4'd15, green: 4'd15, blue: 4'd15};
        end
      end
      PAT_GRADIENT: begin
        color.red   = ramp;
        color.green = pos.row[8:5];
        color.blue  = 4'd15 - ramp;  // blue falls as red rises.
      end
      PAT_WHITE: begin
        color = '{red: 4'd15, green: 4'd15, blue: 4'd15};
      end
      default: begin
        color = '0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Stage register.
  // --------------------------------------------------------------------------

  // Colour, syncs and the visible flag move as one word so the output stage
  // sees them for the same pixel.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_q.rgb   <= '0;
      pix_q.hsync <= ~SYNC_ACTIVE;
      pix_q.vsync <= ~SYNC_ACTIVE;
      visible_q   <= 1'b0;
    end else if (enable) begin
      pix_q.rgb   <= color;
      pix_q.hsync <= pos.hsync;
      pix_q.vsync <= pos.vsync;
      visible_q   <= pos.visible;
    end
  end

  assign pix     = pix_q;
  assign visible = visible_q;

endmodule

// ==== logic/vga_pkg.sv ====
package vga_pkg;

  // --------------------------------------------------------------------------
  // 640x480 at 60 Hz timing, counted in pixel clocks and lines.
  // --------------------------------------------------------------------------

  localparam int H_VISIBLE    = 640;
  localparam int H_FRONT      = 16;
  localparam int H_SYNC       = 96;
  localparam int H_BACK       = 48;
  localparam int H_WHOLE_LINE = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;  // 800 pixels.

  localparam int V_VISIBLE     = 480;
  localparam int V_FRONT       = 10;
  localparam int V_SYNC        = 2;
  localparam int V_BACK        = 33;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;  // 525 lines.

  localparam logic SYNC_ACTIVE = 1'b0;  // both syncs are negative for this mode.

  localparam int COLUMN_BITS = $clog2(H_WHOLE_LINE);
  localparam int ROW_BITS    = $clog2(V_WHOLE_FRAME);

  // --------------------------------------------------------------------------
  // Pipeline payloads.
  // --------------------------------------------------------------------------

  typedef struct packed {
    logic [COLUMN_BITS-1:0] column;
    logic [ROW_BITS-1:0]    row;
    logic                   visible;
    logic                   hsync;
    logic                   vsync;
  } vga_pos_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } vga_rgb_t;

  typedef struct packed {
    vga_rgb_t rgb;
    logic     hsync;
    logic     vsync;
  } vga_pixel_t;

  typedef enum logic [1:0] {
    PAT_BARS     = 2'd0,
    PAT_CHECKER  = 2'd1,
    PAT_GRADIENT = 2'd2,
    PAT_WHITE    = 2'd3
  } pattern_e;

  localparam int BAR_WIDTH     = 80;  // eight bars across the visible line.
  localparam int CHECKER_SHIFT = 5;   // squares of 32 pixels.

  localparam vga_rgb_t BAR_COLORS [8] = '{
    '{red: 4'd15, green: 4'd15, blue: 4'd15},  // white.
    '{red: 4'd15, green: 4'd15, blue: 4'd0},   // yellow.
    '{red: 4'd0,  green: 4'd15, blue: 4'd15},  // cyan.
    '{red: 4'd0,  green: 4'd15, blue: 4'd0},   // green.
    '{red: 4'd15, green: 4'd0,  blue: 4'd15},  // magenta.
    '{red: 4'd15, green: 4'd0,  blue: 4'd0},   // red.
    '{red: 4'd0,  green: 4'd0,  blue: 4'd15},  // blue.
    '{red: 4'd0,  green: 4'd0,  blue: 4'd0}    // black.
  };

endpackage

// ==== logic/vga_timing.sv ====
module vga_timing (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  output vga_pkg::vga_pos_t pos
);
  import vga_pkg::*;

  vga_pos_t               pos_q;
  logic [COLUMN_BITS-1:0] next_column;
  logic [ROW_BITS-1:0]    next_row;
  logic                   end_of_line;
  logic                   end_of_frame;

  // --------------------------------------------------------------------------
  // Position decode.
  // --------------------------------------------------------------------------

  // Builds the full position word for one counter value, so the counters and
  // the decoded fields always load from the same source.
  function automatic vga_pos_t decode(input logic [COLUMN_BITS-1:0] column,
                                      input logic [ROW_BITS-1:0]    row);
    vga_pos_t p;
    logic     h_active;
    logic     v_active;

    h_active = (column >= COLUMN_BITS'(H_VISIBLE + H_FRONT)) &&
               (column <  COLUMN_BITS'(H_VISIBLE + H_FRONT + H_SYNC));
    v_active = (row >= ROW_BITS'(V_VISIBLE + V_FRONT)) &&
               (row <  ROW_BITS'(V_VISIBLE + V_FRONT + V_SYNC));

    p.column  = column;
    p.row     = row;
    p.visible = (column < COLUMN_BITS'(H_VISIBLE)) && (row < ROW_BITS'(V_VISIBLE));
    p.hsync   = h_active ? SYNC_ACTIVE : ~SYNC_ACTIVE;
    p.vsync   = v_active ? SYNC_ACTIVE : ~SYNC_ACTIVE;
    return p;
  endfunction

  // --------------------------------------------------------------------------
  // Beam counters.
  // --------------------------------------------------------------------------

  assign end_of_line  = (pos_q.column == COLUMN_BITS'(H_WHOLE_LINE - 1));
  assign end_of_frame = (pos_q.row == ROW_BITS'(V_WHOLE_FRAME - 1));

  always_comb begin
    next_column = pos_q.column + 1'b1;
    next_row    = pos_q.row;
    if (end_of_line) begin
      next_column = '0;  // the row steps only when the line wraps.
      if (end_of_frame) begin
        next_row = '0;
      end else begin
        next_row = pos_q.row + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos_q <= decode('0, '0);  // (0,0) is visible with both syncs inactive.
    end else if (enable) begin
      pos_q <= decode(next_column, next_row);
    end
  end

  assign pos = pos_q;

endmodule

// ==== logic/vga_top.sv ====
module vga_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  vga_pkg::pattern_e pattern_sel,
  output logic [3:0]        red,
  output logic [3:0]        green,
  output logic [3:0]        blue,
  output logic              hsync,
  output logic              vsync
);
  import vga_pkg::*;

  vga_pos_t   pos;
  vga_pixel_t pix;
  logic       visible;

  // --------------------------------------------------------------------------
  // Timing, pattern and output stages, one enabled cycle each after the
  // position register.
  // --------------------------------------------------------------------------

  vga_timing timing_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (enable),
    .pos    (pos)
  );

  vga_pattern pattern_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable      (enable),
    .pattern_sel (pattern_sel),
    .pos         (pos),
    .pix         (pix),
    .visible     (visible)
  );

  vga_output output_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (enable),
    .pix     (pix),
    .visible (visible),
    .red     (red),
    .green   (green),
    .blue    (blue),
    .hsync   (hsync),
    .vsync   (vsync)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the VGA testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module vga_tb \
  -Mdir obj_dir \
  -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vvga_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tb.f ====
logic/vga_pkg.sv
logic/vga_timing.sv
logic/vga_pattern.sv
logic/vga_output.sv
logic/vga_top.sv
test/vga_clock_gen.sv
test/vga_tb.sv

// ==== test/vga_clock_gen.sv ====
module vga_clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 5;  // full period of 10 time units.

  // --------------------------------------------------------------------------
  // Free-running pixel clock.
  // --------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

// ==== test/vga_tb.sv ====
module vga_tb;
  import vga_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int ENTRY_COUNT  = 4;
  localparam int SHOWN_LIMIT  = 20;  // mismatch lines printed before going quiet.
  localparam int FRAME_CYCLES = H_WHOLE_LINE * V_WHOLE_FRAME;

  typedef enum logic [1:0] {
    EN_ALWAYS,
    EN_RANDOM,
    EN_TOGGLE
  } enable_mode_e;

  typedef struct packed {
    pattern_e     pattern;
    enable_mode_e mode;
    logic [7:0]   frames;
  } stim_entry_t;

  logic       clk;
  logic       rst_n;
  logic       enable;
  pattern_e   pattern_sel;
  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;
  logic       hsync;
  logic       vsync;

  stim_entry_t stim_table [ENTRY_COUNT];

  // Reference pipeline. A position of -1 marks the reset word.
  logic       model_valid = 1'b0;
  int         model_col;
  int         model_row;
  vga_pixel_t stage_exp;
  int         stage_col;
  int         stage_row;
  vga_pixel_t pins_exp;
  int         pins_col;
  int         pins_row;

  int mismatches = 0;
  int errors     = 0;

  vga_clock_gen clock_i (
    .clk (clk)
  );

  vga_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable      (enable),
    .pattern_sel (pattern_sel),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hsync       (hsync),
    .vsync       (vsync)
  );

  // --------------------------------------------------------------------------
  // Stimulus table and run length.
  // --------------------------------------------------------------------------

  function automatic void set_entry(input int idx, input pattern_e pat,
                                    input enable_mode_e mode, input int frames);
    stim_table[idx].pattern = pat;
    stim_table[idx].mode    = mode;
    stim_table[idx].frames  = 8'(frames);
  endfunction

  function automatic int duty_quarters(input enable_mode_e mode);
    case (mode)
      EN_RANDOM: return 3;
      EN_TOGGLE: return 2;
      default:   return 4;
    endcase
  endfunction

  function automatic int timeout_limit();
    int total;
    total = 0;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      total += int'(stim_table[i].frames) * FRAME_CYCLES * 4 /
               duty_quarters(stim_table[i].mode);
    end
    return 2 * total + 1000;
  endfunction

  // --------------------------------------------------------------------------
  // Expected pin values.
  // --------------------------------------------------------------------------

  function automatic vga_pixel_t idle_pixel();
    vga_pixel_t p;
    p.rgb   = '0;
    p.hsync = 1'b1;
    p.vsync = 1'b1;
    return p;
  endfunction

  function automatic vga_pixel_t expected_pixel(input int col, input int row,
                                                input pattern_e pat);
    vga_pixel_t p;
    logic       in_hsync;
    logic       in_vsync;
    in_hsync = (col >= H_VISIBLE + H_FRONT) && (col < H_VISIBLE + H_FRONT + H_SYNC);
    in_vsync = (row >= V_VISIBLE + V_FRONT) && (row < V_VISIBLE + V_FRONT + V_SYNC);
    p.hsync  = !in_hsync;  // both syncs are active low.
    p.vsync  = !in_vsync;
    p.rgb    = '0;
    if (col < H_VISIBLE && row < V_VISIBLE) begin
      case (pat)
        PAT_BARS: begin
          p.rgb = BAR_COLORS[3'(col / BAR_WIDTH)];
        end
        PAT_CHECKER: begin
          if (((col / 32) % 2) != ((row / 32) % 2)) begin
            p.rgb = '{red: 4'd15, green: 4'd15, blue: 4'd15};
          end
        end
        PAT_GRADIENT: begin
          p.rgb.red   = 4'((col / 64) % 16);
          p.rgb.green = 4'((row / 32) % 16);
          p.rgb.blue  = 4'd15 - p.rgb.red;
        end
        PAT_WHITE: begin
          p.rgb = '{red: 4'd15, green: 4'd15, blue: 4'd15};
        end
        default: begin
          p.rgb = '0;
        end
      endcase
    end
    return p;
  endfunction

  task automatic compare_pins();
    vga_pixel_t observed;
    observed.rgb.red   = red;
    observed.rgb.green = green;
    observed.rgb.blue  = blue;
    observed.hsync     = hsync;
    observed.vsync     = vsync;
    assert (observed === pins_exp) else begin
      mismatches++;
      if (mismatches <= SHOWN_LIMIT) begin
        $display("MISMATCH at %0t: pixel (%0d,%0d) expected rgb=%h hs=%b vs=%b",
                 $time, pins_col, pins_row, pins_exp.rgb, pins_exp.hsync,
                 pins_exp.vsync);
        $display("MISMATCH at %0t: got rgb=%h hs=%b vs=%b",
                 $time, observed.rgb, observed.hsync, observed.vsync);
      end
    end
  endtask

  // Pins are compared against the values from before this edge, then the
  // model takes the same step as the DUT.
  always @(posedge clk) begin
    if (model_valid) begin
      compare_pins();
    end
    if (!rst_n) begin
      model_valid = 1'b1;
      model_col   = 0;
      model_row   = 0;
      stage_exp   = idle_pixel();
      stage_col   = -1;
      stage_row   = -1;
      pins_exp    = idle_pixel();
      pins_col    = -1;
      pins_row    = -1;
    end else if (enable) begin
      pins_exp  = stage_exp;
      pins_col  = stage_col;
      pins_row  = stage_row;
      stage_exp = expected_pixel(model_col, model_row, pattern_sel);
      stage_col = model_col;
      stage_row = model_row;
      model_col++;
      if (model_col == H_WHOLE_LINE) begin
        model_col = 0;
        model_row++;
        if (model_row == V_WHOLE_FRAME) begin
          model_row = 0;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus.
  // --------------------------------------------------------------------------

  // Runs the entry's frames, counted in enabled cycles; ends on the falling
  // edge after the last one, with the counter back at (0,0).
  task automatic run_entry(input int entry);
    int   target;
    int   done;
    logic en;
    target = int'(stim_table[entry].frames) * FRAME_CYCLES;
    done   = 0;
    en     = 1'b0;
    while (done < target) begin
      case (stim_table[entry].mode)
        EN_RANDOM: begin
          en = ($urandom() % 4) != 0;
        end
        EN_TOGGLE: begin
          en = !en;
        end
        default: begin
          en = 1'b1;
        end
      endcase
      enable = en;
      if (en) begin
        done++;
      end
      @(negedge clk);
    end
  endtask

  task automatic report_and_finish();
    $display("mismatches: %0d, other errors: %0d", mismatches, errors);
    if (mismatches == 0 && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    rst_n       = 1'b0;
    enable      = 1'b0;
    pattern_sel = PAT_BARS;
    void'($urandom(32'h6e0de996));

    set_entry(0, PAT_BARS, EN_ALWAYS, 1);
    set_entry(1, PAT_CHECKER, EN_ALWAYS, 1);
    set_entry(2, PAT_GRADIENT, EN_RANDOM, 1);
    set_entry(3, PAT_WHITE, EN_TOGGLE, 1);

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < ENTRY_COUNT; i++) begin
      pattern_sel = stim_table[i].pattern;  // switched only with the counter at (0,0).
      run_entry(i);
    end

    // two more enabled cycles push the last pixel of the frame to the pins.
    enable = 1'b1;
    repeat (2) @(negedge clk);
    enable = 1'b0;
    repeat (2) @(negedge clk);

    report_and_finish();
  end

  // --------------------------------------------------------------------------
  // Watchdog.
  // --------------------------------------------------------------------------

  initial begin
    int limit;
    int cycle_count;
    cycle_count = 0;
    @(posedge clk);
    limit = timeout_limit();
    while (cycle_count < limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", limit);
    errors++;
    report_and_finish();
  end

endmodule
